/* Bender.yml */
package:
  name: tempSensorReader

sources:
  - common/i2cPkg.sv
  - common/byteSlotIf.sv
  - i2cMaster/sensorReadFsm.sv
  - i2cMaster/bitPhaseTimer.sv
  - i2cMaster/byteShifter.sv
  - hdl/tempSensorReader.sv
  - target: test
    files:
      - bench/tempReadChecker.sv
      - bench/tempSensorReaderTb.sv

/* bench/tempReadChecker.sv */
`default_nettype none

module tempReadChecker (
    input wire logic FSM_Clk,
    input wire logic reset,
    input wire logic start, busy, done, ackError,
    input wire logic scl, sdaLow, sda,
    input wire logic [7:0] tempMsb, tempLsb,
    input wire logic [31:0] testId,
    input wire logic endTest, timedOut,
    input wire logic [79:0] expLog,
    input wire logic [15:0] expWord,
    input wire logic expAckErr,
    output int passCount,
    output int failCount
);

    timeunit 1ns;
    timeprecision 100ps;

    // start framing, five byte slots, restart, stop
    localparam int Latency = 2 + 5 * 36 + 4 + 3;

    int cyc, startCyc, busyCnt, doneCnt, logCnt, bitCnt;
    logic [79:0] logVec;
    logic [7:0] rxShift;
    logic prevScl, prevSda, testBad;

    function automatic string testName(input int id);
        if (id == 0) return "resetValues";
        if (id == 1) return "fixedRead";
        if (id <= 11) return $sformatf("randomRead%0d", id - 2);
        if (id == 12) return "silentAddress";
        if (id == 13) return "ackRecovery";
        return "startWhileBusy";
    endfunction

    task automatic mismatch(input string what, input logic [79:0] expVal,
                            input logic [79:0] actVal);
        $display("Mismatch in %s, %s: expected %0h, actual %0h",
                 testName(testId), what, expVal, actVal);
        testBad = 1'b1;
    endtask

    task automatic compareOutputs();
        if (tempMsb !== expWord[15:8]) mismatch("tempMsb", expWord[15:8], tempMsb);
        if (tempLsb !== expWord[7:0]) mismatch("tempLsb", expWord[7:0], tempLsb);
        if (ackError !== expAckErr) mismatch("ackError", expAckErr, ackError);
    endtask

    task automatic logEvent(input logic [9:0] entry);
        logVec = {logVec[69:0], entry};
        logCnt++;
    endtask

    task automatic clearTest();
        doneCnt = 0;
        logCnt = 0;
        logVec = '0;
        testBad = 1'b0;
    endtask

    task automatic finishTest();
        if (timedOut) begin
            $display("Test %s: done did not arrive within 400 cycles", testName(testId));
            testBad = 1'b1;
        end
        // bus and status back at rest
        if (busy !== 1'b0) mismatch("busy", 0, busy);
        if (done !== 1'b0) mismatch("done", 0, done);
        if (scl !== 1'b1) mismatch("scl", 1, scl);
        if (sdaLow !== 1'b0) mismatch("sdaLow", 0, sdaLow);
        if (testId == 0) compareOutputs();
        if (doneCnt != ((testId == 0) ? 0 : 1)) mismatch("done pulses", testId != 0, doneCnt);
        if (logCnt != ((testId == 0) ? 0 : 8)) begin
            mismatch("bus event count", (testId == 0) ? 0 : 8, logCnt);
        end else if (logVec !== expLog) begin
            mismatch("bus log", expLog, logVec);
        end
        if (testBad) failCount++;
        else passCount++;
        $display("test %s: %s", testName(testId), testBad ? "failed" : "passed");
        clearTest();
    endtask

    always @(negedge FSM_Clk) begin
        if (reset) begin
            cyc = 0;
            startCyc = 0;
            busyCnt = 0;
            bitCnt = 0;
            prevScl = 1'b1;
            prevSda = 1'b1;
            passCount = 0;
            failCount = 0;
            clearTest();
        end else begin
            cyc++;
            // a start while busy must be ignored
            if (start && !busy) begin
                startCyc = cyc;
                busyCnt = 0;
            end
            if (busy) busyCnt++;
            if (done) begin
                doneCnt++;
                if (cyc - startCyc - 1 != Latency) begin
                    mismatch("start to done cycles", Latency, cyc - startCyc - 1);
                end
                if (busyCnt != Latency) mismatch("busy cycles", Latency, busyCnt);
                compareOutputs();
            end
            // bus decode
            if (prevScl && scl && prevSda && !sda) begin
                logEvent(10'h200);
                bitCnt = 0;
            end else if (prevScl && scl && !prevSda && sda) begin
                logEvent(10'h300);
            end else if (!prevScl && scl) begin
                if (bitCnt == 8) begin
                    logEvent({1'b0, sda, rxShift});
                    bitCnt = 0;
                end else begin
                    rxShift = {rxShift[6:0], sda};
                    bitCnt++;
                end
            end
            prevScl = scl;
            prevSda = sda;
            if (endTest) finishTest();
        end
    end

endmodule

`default_nettype wire

/* bench/tempSensorReaderTb.sv */
`default_nettype none

module tempSensorReaderTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [7:0] RegAddr = 8'h00;
    localparam int NumTests = 15;
    localparam int DoneTimeout = 400;

    logic FSM_Clk;
    logic reset;
    logic start;
    logic scl, sdaLow, sda;
    logic busy, done, ackError;
    logic [7:0] tempMsb, tempLsb;

    // sensor model state
    logic modelLow;
    logic [15:0] tempWord;
    logic silent;
    logic prevScl, prevSda, firstByte, addressed, reading, sending, masterAcked;
    int bitCnt;
    int txIdx;
    logic [7:0] rxShift, txShift;

    // expected values handed to the checker
    int testId;
    logic endTest, timedOut;
    logic [79:0] expLog;
    logic [15:0] expWord;
    logic expAckErr;
    int passCount, failCount;
    integer seed;
    logic [15:0] randWord;

    // open-drain line with pull-up
    assign sda = !(sdaLow || modelLow);

    tempSensorReader #(
        .DeviceAddr(7'h48),
        .RegAddr(RegAddr)
    ) dut (
        .FSM_Clk(FSM_Clk),
        .reset(reset),
        .start(start),
        .sdaIn(sda),
        .scl(scl),
        .sdaLow(sdaLow),
        .busy(busy),
        .done(done),
        .ackError(ackError),
        .tempMsb(tempMsb),
        .tempLsb(tempLsb)
    );

    tempReadChecker readCheck (
        .FSM_Clk(FSM_Clk),
        .reset(reset),
        .start(start),
        .busy(busy),
        .done(done),
        .ackError(ackError),
        .scl(scl),
        .sdaLow(sdaLow),
        .sda(sda),
        .tempMsb(tempMsb),
        .tempLsb(tempLsb),
        .testId(testId),
        .endTest(endTest),
        .timedOut(timedOut),
        .expLog(expLog),
        .expWord(expWord),
        .expAckErr(expAckErr),
        .passCount(passCount),
        .failCount(failCount)
    );

    initial begin
        FSM_Clk = 1'b0;
        forever #2 FSM_Clk = ~FSM_Clk;
    end

    // start logs as 10'h200 and stop as 10'h300
    // each byte logs as {0, ack, byte}
    function automatic logic [96:0] expectedRead(input logic [15:0] word, input logic quiet);
        logic [79:0] busLog;
        logic [15:0] data;
        // a silent sensor leaves the line high
        data = quiet ? 16'hffff : word;
        busLog = {10'h200, 1'b0, quiet, 8'h90, 1'b0, quiet, RegAddr, 10'h200,
                  1'b0, quiet, 8'h91, 2'b00, data[15:8], 2'b01, data[7:0], 10'h300};
        return {busLog, data, quiet};
    endfunction

    // sensor model sampled between clock edges
    always @(negedge FSM_Clk) begin
        if (reset) begin
            prevScl = 1'b1;
            prevSda = 1'b1;
            bitCnt = 0;
            addressed = 1'b0;
            sending = 1'b0;
            firstByte = 1'b0;
            modelLow <= 1'b0;
        end else begin
            if (prevScl && scl && prevSda && !sda) begin
                bitCnt = 0;
                firstByte = 1'b1;
                sending = 1'b0;
            end else if (prevScl && scl && !prevSda && sda) begin
                addressed = 1'b0;
                sending = 1'b0;
            end else if (!prevScl && scl) begin
                if (bitCnt < 8) begin
                    rxShift = {rxShift[6:0], sda};
                end else begin
                    masterAcked = !sda;
                end
                bitCnt++;
            end else if (prevScl && !scl) begin
                if (bitCnt == 8) begin
                    if (sending) begin
                        // release for the master ack
                        modelLow <= 1'b0;
                    end else if (firstByte) begin
                        addressed = !silent && (rxShift[7:1] == 7'h48);
                        reading = rxShift[0];
                        firstByte = 1'b0;
                        modelLow <= addressed;
                    end else begin
                        modelLow <= addressed;
                    end
                end else if (bitCnt == 9) begin
                    bitCnt = 0;
                    if (addressed && reading) begin
                        if (!sending) begin
                            sending = 1'b1;
                            txIdx = 0;
                        end else if (masterAcked) begin
                            txIdx = 1;
                        end else begin
                            sending = 1'b0;
                        end
                    end
                    if (sending) begin
                        txShift = (txIdx == 0) ? tempWord[15:8] : tempWord[7:0];
                        modelLow <= !txShift[7];
                    end else begin
                        modelLow <= 1'b0;
                    end
                end else if (sending) begin
                    modelLow <= !txShift[7 - bitCnt];
                end
            end
            prevScl = scl;
            prevSda = sda;
        end
    end

    task automatic closeTest(input logic late);
        repeat (2) @(posedge FSM_Clk);
        #1;
        timedOut = late;
        endTest = 1'b1;
        @(posedge FSM_Clk);
        #1;
        endTest = 1'b0;
    endtask

    task automatic runRead(input int id, input logic [15:0] word, input logic quiet,
                           input logic extraStart);
        int waited;
        testId = id;
        tempWord = word;
        silent = quiet;
        {expLog, expWord, expAckErr} = expectedRead(word, quiet);
        start = 1'b1;
        @(posedge FSM_Clk);
        #1;
        start = 1'b0;
        if (extraStart) begin
            // second pulse in the middle of the transaction
            repeat (20) @(posedge FSM_Clk);
            #1;
            start = 1'b1;
            @(posedge FSM_Clk);
            #1;
            start = 1'b0;
        end
        waited = 0;
        while (done !== 1'b1 && waited < DoneTimeout) begin
            @(posedge FSM_Clk);
            #1;
            waited++;
        end
        closeTest(done !== 1'b1);
    endtask

    initial begin
        seed = 32'hf3dfc1b8;
        start = 1'b0;
        reset = 1'b1;
        modelLow = 1'b0;
        testId = 0;
        endTest = 1'b0;
        timedOut = 1'b0;
        expLog = '0;
        expWord = '0;
        expAckErr = 1'b0;
        tempWord = '0;
        silent = 1'b0;
        repeat (4) @(posedge FSM_Clk);
        #1;
        reset = 1'b0;
        closeTest(1'b0);
        runRead(1, 16'h0c80, 1'b0, 1'b0);
        for (int i = 0; i < 10; i++) begin
            randWord = $random(seed);
            runRead(2 + i, randWord, 1'b0, 1'b0);
        end
        runRead(12, 16'h1e40, 1'b1, 1'b0);
        runRead(13, 16'h1e40, 1'b0, 1'b0);
        runRead(14, 16'hf380, 1'b0, 1'b1);
        repeat (2) @(posedge FSM_Clk);
        $display("tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0 && passCount == NumTests) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* common/byteSlotIf.sv */
`default_nettype none

interface byteSlotIf;

    // set by the sequencer for the current slot
    logic slotActive;
    i2cPkg::byteT txByte;
    logic rxMode;
    logic masterNack;

    // position within the slot from the bit timer
    i2cPkg::phaseT phase;
    i2cPkg::bitIdxT bitIdx;
    logic slotLast;

    modport seq (
        output slotActive, txByte, rxMode, masterNack,
        input slotLast
    );

    modport timer (
        input slotActive,
        output phase, bitIdx, slotLast
    );

    modport shifter (
        input slotActive, txByte, rxMode, masterNack,
        input phase, bitIdx, slotLast
    );

endinterface

`default_nettype wire

/* common/i2cPkg.sv */
`default_nettype none

package i2cPkg;

    // bus widths
    localparam int ByteWidth = 8;
    localparam int DevAddrWidth = 7;
    localparam int BitIdxWidth = 4;
    localparam int PhaseWidth = 2;

    // one byte on the bus in either direction
    typedef logic [ByteWidth-1:0] byteT;

    // 7-bit device address without the r/w bit
    typedef logic [DevAddrWidth-1:0] devAddrT;

    // bit position in a byte slot with 8 as the acknowledge bit
    typedef logic [BitIdxWidth-1:0] bitIdxT;

    // clock phase within one bit
    typedef logic [PhaseWidth-1:0] phaseT;

    // bit timing
    localparam int PhasesPerBit = 4;
    localparam phaseT SamplePhase = 2'd2;
    localparam bitIdxT AckBitIdx = 4'd8;

    // sequencer states in bus order
    typedef enum logic [3:0] {
        idle,
        start,
        writeAddr,
        regAddr,
        restart,
        readAddr,
        readMsb,
        readLsb,
        stop
    } readStateT;

endpackage

`default_nettype wire

/* files.f */
common/i2cPkg.sv
common/byteSlotIf.sv
i2cMaster/sensorReadFsm.sv
i2cMaster/bitPhaseTimer.sv
i2cMaster/byteShifter.sv
hdl/tempSensorReader.sv
bench/tempReadChecker.sv
bench/tempSensorReaderTb.sv

/* hdl/tempSensorReader.sv */
`default_nettype none

module tempSensorReader #(
    parameter i2cPkg::devAddrT DeviceAddr = 7'h48,
    parameter i2cPkg::byteT RegAddr = 8'h00
) (
    input wire logic FSM_Clk,
    input wire logic reset,
    input wire logic start,
    input wire logic sdaIn,
    output logic scl,
    output logic sdaLow,
    output logic busy,
    output logic done,
    output logic ackError,
    output i2cPkg::byteT tempMsb,
    output i2cPkg::byteT tempLsb
);

    byteSlotIf slotBus ();

    i2cPkg::byteT rxByte;
    logic frameScl;
    logic frameSdaLow;
    logic clearErr;

    // transaction sequencer
    sensorReadFsm #(
        .DeviceAddr(DeviceAddr),
        .RegAddr(RegAddr)
    ) u_sensorReadFsm (
        .FSM_Clk(FSM_Clk),
        .reset(reset),
        .start(start),
        .slot(slotBus),
        .rxByte(rxByte),
        .frameScl(frameScl),
        .frameSdaLow(frameSdaLow),
        .clearErr(clearErr),
        .busy(busy),
        .done(done),
        .tempMsb(tempMsb),
        .tempLsb(tempLsb)
    );

    bitPhaseTimer u_bitPhaseTimer (
        .FSM_Clk(FSM_Clk),
        .reset(reset),
        .slot(slotBus)
    );

    // pins and ack capture
    byteShifter u_byteShifter (
        .FSM_Clk(FSM_Clk),
        .reset(reset),
        .slot(slotBus),
        .frameScl(frameScl),
        .frameSdaLow(frameSdaLow),
        .clearErr(clearErr),
        .sdaIn(sdaIn),
        .scl(scl),
        .sdaLow(sdaLow),
        .rxByte(rxByte),
        .ackError(ackError)
    );

endmodule

`default_nettype wire

/* i2cMaster/bitPhaseTimer.sv */
`default_nettype none

module bitPhaseTimer (
    input wire logic FSM_Clk,
    input wire logic reset,
    byteSlotIf.timer slot
);

    localparam i2cPkg::phaseT LastPhase = i2cPkg::phaseT'(i2cPkg::PhasesPerBit - 1);

    i2cPkg::phaseT phase;
    i2cPkg::bitIdxT bitIdx;
    logic bitEnd;

    assign bitEnd = (phase == LastPhase);

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            phase <= '0;
            bitIdx <= '0;
        end else if (!slot.slotActive) begin
            // hold at the start of a slot
            phase <= '0;
            bitIdx <= '0;
        end else begin
            phase <= phase + 2'd1;
            if (bitEnd) begin
                // wrap after the ack bit so back to back slots line up
                if (bitIdx == i2cPkg::AckBitIdx) begin
                    bitIdx <= '0;
                end else begin
                    bitIdx <= bitIdx + 4'd1;
                end
            end
        end
    end

    assign slot.phase = phase;
    assign slot.bitIdx = bitIdx;

    // last cycle of the ack bit
    assign slot.slotLast = slot.slotActive && bitEnd && (bitIdx == i2cPkg::AckBitIdx);

endmodule

`default_nettype wire

/* i2cMaster/byteShifter.sv */
`default_nettype none

module byteShifter (
    input wire logic FSM_Clk,
    input wire logic reset,
    byteSlotIf.shifter slot,
    input wire logic frameScl,
    input wire logic frameSdaLow,
    input wire logic clearErr,
    input wire logic sdaIn,
    output logic scl,
    output logic sdaLow,
    output i2cPkg::byteT rxByte,
    output logic ackError
);

    logic ackBit;
    logic samplePoint;
    logic [2:0] txBitSel;

    assign ackBit = (slot.bitIdx == i2cPkg::AckBitIdx);
    assign samplePoint = slot.slotActive && (slot.phase == i2cPkg::SamplePhase);

    // msb goes out first
    assign txBitSel = 3'd7 - slot.bitIdx[2:0];

    // pin drivers
    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            scl <= 1'b1;
            sdaLow <= 1'b0;
        end else if (slot.slotActive) begin
            // scl high in the middle two phases
            scl <= (slot.phase == 2'd1) || (slot.phase == 2'd2);
            if (slot.phase == 2'd0) begin
                if (ackBit) begin
                    // master ack in read slots and slave ack otherwise
                    sdaLow <= slot.rxMode && !slot.masterNack;
                end else begin
                    sdaLow <= !slot.rxMode && !slot.txByte[txBitSel];
                end
            end
        end else begin
            scl <= frameScl;
            sdaLow <= frameSdaLow;
        end
    end

    // data bits from the slave
    always_ff @(posedge FSM_Clk) begin
        if (samplePoint && slot.rxMode && !ackBit) begin
            rxByte <= {rxByte[6:0], sdaIn};
        end
    end

    // sticky until the next transaction begins
    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            ackError <= 1'b0;
        end else if (clearErr) begin
            ackError <= 1'b0;
        end else if (samplePoint && ackBit && !slot.rxMode && sdaIn) begin
            // line left high means no slave ack
            ackError <= 1'b1;
        end
    end

endmodule

`default_nettype wire

/* i2cMaster/sensorReadFsm.sv */
`default_nettype none

module sensorReadFsm #(
    parameter i2cPkg::devAddrT DeviceAddr = 7'h48,
    parameter i2cPkg::byteT RegAddr = 8'h00
) (
    input wire logic FSM_Clk,
    input wire logic reset,
    input wire logic start,
    byteSlotIf.seq slot,
    input wire i2cPkg::byteT rxByte,
    output logic frameScl,
    output logic frameSdaLow,
    output logic clearErr,
    output logic busy,
    output logic done,
    output i2cPkg::byteT tempMsb,
    output i2cPkg::byteT tempLsb
);

    i2cPkg::readStateT state;
    i2cPkg::readStateT nextState;

    // cycle counter for start, restart and stop framing
    logic [1:0] frameStep;

    always_comb begin
        nextState = state;
        case (state)
            i2cPkg::idle: if (start) nextState = i2cPkg::start;
            i2cPkg::start: if (frameStep == 2'd1) nextState = i2cPkg::writeAddr;
            i2cPkg::writeAddr: if (slot.slotLast) nextState = i2cPkg::regAddr;
            i2cPkg::regAddr: if (slot.slotLast) nextState = i2cPkg::restart;
            i2cPkg::restart: if (frameStep == 2'd3) nextState = i2cPkg::readAddr;
            i2cPkg::readAddr: if (slot.slotLast) nextState = i2cPkg::readMsb;
            i2cPkg::readMsb: if (slot.slotLast) nextState = i2cPkg::readLsb;
            i2cPkg::readLsb: if (slot.slotLast) nextState = i2cPkg::stop;
            i2cPkg::stop: if (frameStep == 2'd2) nextState = i2cPkg::idle;
            default: nextState = i2cPkg::idle;
        endcase
    end

    always_ff @(posedge FSM_Clk) begin
        if (reset) begin
            state <= i2cPkg::idle;
            frameStep <= '0;
            done <= 1'b0;
            tempMsb <= '0;
            tempLsb <= '0;
        end else begin
            state <= nextState;
            // restart the step count on every state change
            if (nextState != state) begin
                frameStep <= '0;
            end else begin
                frameStep <= frameStep + 2'd1;
            end
            done <= (state == i2cPkg::stop) && (nextState == i2cPkg::idle);
            if (slot.slotLast && state == i2cPkg::readMsb) begin
                tempMsb <= rxByte;
            end
            if (slot.slotLast && state == i2cPkg::readLsb) begin
                tempLsb <= rxByte;
            end
        end
    end

    // byte slot setup
    assign slot.slotActive = state inside {i2cPkg::writeAddr, i2cPkg::regAddr,
                                           i2cPkg::readAddr, i2cPkg::readMsb,
                                           i2cPkg::readLsb};
    assign slot.rxMode = state inside {i2cPkg::readMsb, i2cPkg::readLsb};
    // ack the first data byte and nack the last one
    assign slot.masterNack = (state == i2cPkg::readLsb);

    always_comb begin
        case (state)
            i2cPkg::writeAddr: slot.txByte = {DeviceAddr, 1'b0};
            i2cPkg::regAddr: slot.txByte = RegAddr;
            i2cPkg::readAddr: slot.txByte = {DeviceAddr, 1'b1};
            default: slot.txByte = '1;
        endcase
    end

    // framing levels only used between slots
    always_comb begin
        frameScl = 1'b1;
        frameSdaLow = 1'b0;
        case (state)
            i2cPkg::start: begin
                // sda falls while scl high and then scl goes low
                frameScl = (frameStep == 2'd0);
                frameSdaLow = 1'b1;
            end
            i2cPkg::restart: begin
                frameScl = (frameStep == 2'd1) || (frameStep == 2'd2);
                frameSdaLow = (frameStep >= 2'd2);
            end
            i2cPkg::stop: begin
                // sda rises last while scl is high
                frameScl = (frameStep != 2'd0);
                frameSdaLow = (frameStep != 2'd2);
            end
            default: begin
                frameScl = 1'b1;
                frameSdaLow = 1'b0;
            end
        endcase
    end

    assign busy = (state != i2cPkg::idle);
    assign clearErr = (state == i2cPkg::idle) && start;

endmodule

`default_nettype wire
